/* pipe_ctrl.f */
+incdir+dv
hw/pipe_ctrl_pkg.sv
hw/forward_unit.sv
hw/redirect_unit.sv
hw/trap_csr.sv
hw/pipe_ctrl_top.sv
dv/clock_gen.sv
dv/tb_pipe_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ns --top-module tb_pipe_ctrl \
    -f pipe_ctrl.f -o tb_pipe_ctrl \
    && ./obj_dir/tb_pipe_ctrl > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && { echo "Simulation reported failures"; exit 1; }
echo "Simulation clean"
exit 0

/* dv/pipe_ctrl_ref.svh */
`ifndef PIPE_CTRL_REF_SVH
`define PIPE_CTRL_REF_SVH

typedef struct packed {
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
} trap_regs_t;

// Operand seen by EX for one source register.
function automatic logic [xlen-1:0] operand_after_bypass(
    input logic [reg_addr_w-1:0] src,
    input logic [xlen-1:0]       reg_value,
    input ex_stage_t             ex_s,
    input mem_stage_t            mem_s
);
    if (src == '0) begin
        return reg_value;
    end
    if (ex_s.valid && ex_s.reg_wen && (ex_s.rd == src)) begin
        return ex_s.result;
    end
    if (mem_s.valid && mem_s.reg_wen && (mem_s.rd == src)) begin
        return mem_s.mem_ren ? mem_s.rdata : mem_s.result;
    end
    return reg_value;
endfunction

function automatic logic ex_takes_redirect(input ex_stage_t ex_s);
    return ex_s.valid && (ex_s.jump || ex_s.fence_i || (ex_s.branch && ex_s.result[0]));
endfunction

function automatic redirect_t predict_redirect(
    input id_stage_t       id_s,
    input ex_stage_t       ex_s,
    input logic [xlen-1:0] mtvec_v,
    input logic [xlen-1:0] mepc_v
);
    redirect_t r;
    r = '0;
    if (ex_takes_redirect(ex_s)) begin
        r.valid = 1'b1;
        r.icache_clr = ex_s.fence_i;
        if (ex_s.jump) begin
            r.target = ex_s.result;
        end else if (ex_s.branch && ex_s.result[0]) begin
            r.target = ex_s.pc + ex_s.imm;
        end else begin
            r.target = ex_s.pc + 32'd4;
        end
    end else if (id_s.valid && (id_s.ecall || id_s.mret)) begin
        r.valid = 1'b1;
        r.target = id_s.ecall ? mtvec_v : mepc_v;
    end
    r.flush = r.valid;
    return r;
endfunction

function automatic logic ecall_is_taken(input id_stage_t id_s, input ex_stage_t ex_s);
    return id_s.valid && id_s.ecall && !ex_takes_redirect(ex_s);
endfunction

function automatic trap_regs_t next_trap_regs(
    input trap_regs_t      cur,
    input csr_wr_t         wr,
    input logic            take,
    input logic [xlen-1:0] pc
);
    trap_regs_t nxt;
    nxt = cur;
    if (wr.valid && (wr.addr == csr_mtvec)) nxt.mtvec = wr.data;
    if (wr.valid && (wr.addr == csr_mepc)) nxt.mepc = wr.data;
    if (wr.valid && (wr.addr == csr_mcause)) nxt.mcause = wr.data;
    // Ecall capture lands on top of any same-cycle write.
    if (take) begin
        nxt.mepc = pc;
        nxt.mcause = cause_ecall_m;
    end
    return nxt;
endfunction

function automatic logic [xlen-1:0] csr_value(input trap_regs_t regs, input csr_addr_e addr);
    case (addr)
        csr_mtvec:  return regs.mtvec;
        csr_mepc:   return regs.mepc;
        csr_mcause: return regs.mcause;
        default:    return '0;
    endcase
endfunction

`endif

/* dv/tb_pipe_ctrl.sv */
`timescale 1ns/1ns

module tb_pipe_ctrl;
    import pipe_ctrl_pkg::*;

    `include "pipe_ctrl_ref.svh"

    localparam int clk_period = 20;
    localparam int random_cycles = 300;
    localparam int watchdog_cycles = 5 + 500 + 50;

    logic            clock;
    logic            reset;
    id_stage_t       id;
    ex_stage_t       ex;
    mem_stage_t      mem;
    csr_wr_t         csr_wr;
    csr_addr_e       csr_raddr;
    logic [xlen-1:0] rs1_fwd;
    logic [xlen-1:0] rs2_fwd;
    redirect_t       redirect;
    logic [xlen-1:0] csr_rdata;

    // Values applied at the next rising edge.
    id_stage_t  id_d;
    ex_stage_t  ex_d;
    mem_stage_t mem_d;
    csr_wr_t    wr_d;
    csr_addr_e  raddr_d;

    trap_regs_t shadow;
    redirect_t  exp_redir;
    integer     seed = 78;
    integer     errors = 0;
    integer     checks = 0;

    clock_gen #(.half_period(clk_period / 2), .reset_cycles(5)) u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    pipe_ctrl_top dut (
        .clock     (clock),
        .reset     (reset),
        .id        (id),
        .ex        (ex),
        .mem       (mem),
        .csr_wr    (csr_wr),
        .csr_raddr (csr_raddr),
        .rs1_fwd   (rs1_fwd),
        .rs2_fwd   (rs2_fwd),
        .redirect  (redirect),
        .csr_rdata (csr_rdata)
    );

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        checks = checks + 1;
        if (got !== want) begin
            errors = errors + 1;
            $display("MISMATCH %s: got %08h, expected %08h at %0t", name, got, want, $time);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic clear_next();
        id_d = '0;
        ex_d = '0;
        mem_d = '0;
        wr_d = '0;
        raddr_d = csr_mtvec;
    endtask

    task automatic step();
        @(posedge clock);
        id <= id_d;
        ex <= ex_d;
        mem <= mem_d;
        csr_wr <= wr_d;
        csr_raddr <= raddr_d;
    endtask

    // Just before the next edge, when all outputs have settled.
    task automatic wait_sample();
        #(clk_period - 2);
    endtask

    task automatic write_csr(input csr_addr_e addr, input logic [31:0] data);
        clear_next();
        wr_d.valid = 1'b1;
        wr_d.addr = addr;
        wr_d.data = data;
        step();
    endtask

    task automatic check_csr_read(input csr_addr_e addr, input string name,
                                  input logic [31:0] want);
        clear_next();
        raddr_d = addr;
        step();
        wait_sample();
        compare_word(name, csr_rdata, want);
    endtask

    task automatic expect_redirect(input logic valid, input logic [31:0] target,
                                   input logic clr);
        compare_word("redirect.valid", {31'd0, redirect.valid}, {31'd0, valid});
        compare_word("redirect.flush", {31'd0, redirect.flush}, {31'd0, valid});
        compare_word("redirect.icache_clr", {31'd0, redirect.icache_clr}, {31'd0, clr});
        if (valid) begin
            compare_word("redirect.target", redirect.target, target);
        end
    endtask

    task automatic draw_random_stages();
        logic [31:0] sel;
        sel = $random(seed);
        id_d.valid = sel[0];
        id_d.pc = $random(seed);
        id_d.rs1 = {3'b000, sel[2:1]};
        id_d.rs2 = {3'b000, sel[4:3]};
        id_d.rs1_value = $random(seed);
        id_d.rs2_value = $random(seed);
        // Rare traps, so most cycles stay on the bypass path.
        id_d.ecall = (sel[9:6] == 4'd0);
        id_d.mret = (sel[9:6] == 4'd1);
        ex_d.valid = sel[10];
        ex_d.pc = $random(seed);
        ex_d.imm = $random(seed);
        ex_d.result = $random(seed);
        ex_d.rd = {3'b000, sel[12:11]};
        ex_d.reg_wen = sel[13];
        ex_d.jump = (sel[16:14] == 3'd0);
        ex_d.branch = (sel[16:14] == 3'd1);
        ex_d.fence_i = (sel[16:14] == 3'd2);
        mem_d.valid = sel[17];
        mem_d.rd = {3'b000, sel[19:18]};
        mem_d.reg_wen = sel[20];
        mem_d.mem_ren = sel[21];
        mem_d.result = $random(seed);
        mem_d.rdata = $random(seed);
        wr_d.valid = (sel[25:22] == 4'd0);
        wr_d.data = $random(seed);
        case (sel[27:26])
            2'd0:    wr_d.addr = csr_mtvec;
            2'd1:    wr_d.addr = csr_mepc;
            default: wr_d.addr = csr_mcause;
        endcase
        case (sel[29:28])
            2'd0:    raddr_d = csr_mtvec;
            2'd1:    raddr_d = csr_mepc;
            default: raddr_d = csr_mcause;
        endcase
    endtask

    // Shadow trap registers.
    always @(posedge clock) begin
        if (reset) begin
            shadow <= '0;
        end else begin
            shadow <= next_trap_regs(shadow, csr_wr, ecall_is_taken(id, ex), id.pc);
        end
    end

    always begin
        @(posedge clock);
        wait_sample();
        if (!reset) begin
            exp_redir = predict_redirect(id, ex, shadow.mtvec, shadow.mepc);
            compare_word("rs1_fwd", rs1_fwd, operand_after_bypass(id.rs1, id.rs1_value, ex, mem));
            compare_word("rs2_fwd", rs2_fwd, operand_after_bypass(id.rs2, id.rs2_value, ex, mem));
            expect_redirect(exp_redir.valid, exp_redir.target, exp_redir.icache_clr);
            compare_word("csr_rdata", csr_rdata, csr_value(shadow, csr_raddr));
        end
    end

    initial begin
        id <= '0;
        ex <= '0;
        mem <= '0;
        csr_wr <= '0;
        csr_raddr <= csr_mtvec;
        clear_next();
        wait (!reset);

        repeat (random_cycles) begin
            draw_random_stages();
            step();
        end

        // Register 0 ignores matching producers.
        clear_next();
        id_d = '{valid: 1'b1, rs1_value: 32'h1111_0000, rs2_value: 32'h2222_0000, default: '0};
        ex_d = '{valid: 1'b1, reg_wen: 1'b1, result: 32'hdead_0001, default: '0};
        mem_d = '{valid: 1'b1, reg_wen: 1'b1, result: 32'hdead_0002, default: '0};
        step();
        wait_sample();
        compare_word("rs1_fwd", rs1_fwd, 32'h1111_0000);
        compare_word("rs2_fwd", rs2_fwd, 32'h2222_0000);

        // EX and MEM both hit, EX is younger.
        id_d.rs1 = 5'd5;
        id_d.rs2 = 5'd5;
        ex_d.rd = 5'd5;
        ex_d.result = 32'haaaa_0005;
        mem_d.rd = 5'd5;
        step();
        wait_sample();
        compare_word("rs1_fwd", rs1_fwd, 32'haaaa_0005);
        compare_word("rs2_fwd", rs2_fwd, 32'haaaa_0005);

        // Load data against ALU result in MEM.
        clear_next();
        id_d = '{valid: 1'b1, rs1: 5'd6, rs2: 5'd7, rs2_value: 32'h0000_7777, default: '0};
        mem_d = '{valid: 1'b1, rd: 5'd6, reg_wen: 1'b1, mem_ren: 1'b1,
                  result: 32'h0bad_0006, rdata: 32'hc0de_0006};
        step();
        wait_sample();
        compare_word("rs1_fwd", rs1_fwd, 32'hc0de_0006);
        compare_word("rs2_fwd", rs2_fwd, 32'h0000_7777);
        mem_d.mem_ren = 1'b0;
        step();
        wait_sample();
        compare_word("rs1_fwd", rs1_fwd, 32'h0bad_0006);

        // EX redirects.
        clear_next();
        ex_d = '{valid: 1'b1, pc: 32'h100, jump: 1'b1, result: 32'h0000_1000, default: '0};
        step();
        wait_sample();
        expect_redirect(1'b1, 32'h0000_1000, 1'b0);
        ex_d = '{valid: 1'b1, pc: 32'h200, imm: 32'h40, branch: 1'b1, result: 32'd1, default: '0};
        step();
        wait_sample();
        expect_redirect(1'b1, 32'h200 + 32'h40, 1'b0);
        ex_d.result = 32'd0;
        step();
        wait_sample();
        expect_redirect(1'b0, 32'h0, 1'b0);
        ex_d = '{valid: 1'b1, pc: 32'h300, fence_i: 1'b1, default: '0};
        step();
        wait_sample();
        expect_redirect(1'b1, 32'h300 + 32'd4, 1'b1);
        ex_d = '{jump: 1'b1, result: 32'h0000_1000, default: '0};
        step();
        wait_sample();
        expect_redirect(1'b0, 32'h0, 1'b0);

        // Trap vector write, then ecall.
        write_csr(csr_mtvec, 32'h8000_0100);
        check_csr_read(csr_mtvec, "csr_rdata(mtvec)", 32'h8000_0100);
        clear_next();
        id_d = '{valid: 1'b1, pc: 32'h0000_1234, ecall: 1'b1, default: '0};
        step();
        wait_sample();
        expect_redirect(1'b1, 32'h8000_0100, 1'b0);
        check_csr_read(csr_mepc, "csr_rdata(mepc)", 32'h0000_1234);
        check_csr_read(csr_mcause, "csr_rdata(mcause)", 32'd11);

        // Return through a written mepc.
        write_csr(csr_mepc, 32'h0000_4444);
        write_csr(csr_mcause, 32'd7);
        clear_next();
        id_d = '{valid: 1'b1, pc: 32'h0000_2000, mret: 1'b1, default: '0};
        step();
        wait_sample();
        expect_redirect(1'b1, 32'h0000_4444, 1'b0);

        // Taken branch squashes the ecall behind it.
        clear_next();
        ex_d = '{valid: 1'b1, pc: 32'h500, imm: 32'h20, branch: 1'b1, result: 32'd1, default: '0};
        id_d = '{valid: 1'b1, pc: 32'h0000_9990, ecall: 1'b1, default: '0};
        step();
        wait_sample();
        expect_redirect(1'b1, 32'h500 + 32'h20, 1'b0);
        check_csr_read(csr_mepc, "csr_rdata(mepc)", 32'h0000_4444);
        check_csr_read(csr_mcause, "csr_rdata(mcause)", 32'd7);

        // Ecall capture beats a same-cycle mepc write.
        clear_next();
        id_d = '{valid: 1'b1, pc: 32'h0000_5550, ecall: 1'b1, default: '0};
        wr_d.valid = 1'b1;
        wr_d.addr = csr_mepc;
        wr_d.data = 32'hdead_0000;
        step();
        check_csr_read(csr_mepc, "csr_rdata(mepc)", 32'h0000_5550);

        clear_next();
        step();
        // After the last compare, ahead of the next edge.
        #(clk_period - 1);
        finish_run();
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        errors = errors + 1;
        finish_run();
    end

endmodule

/* dv/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 5
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    // Released on a rising edge, like any synchronous input.
    initial begin
        reset <= 1'b1;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

/* hw/pipe_ctrl_top.sv */
`timescale 1ns/1ns

module pipe_ctrl_top (
    input  logic                           clock,
    input  logic                           reset,
    input  pipe_ctrl_pkg::id_stage_t       id,
    input  pipe_ctrl_pkg::ex_stage_t       ex,
    input  pipe_ctrl_pkg::mem_stage_t      mem,
    input  pipe_ctrl_pkg::csr_wr_t         csr_wr,
    input  pipe_ctrl_pkg::csr_addr_e       csr_raddr,
    output logic [pipe_ctrl_pkg::xlen-1:0] rs1_fwd,
    output logic [pipe_ctrl_pkg::xlen-1:0] rs2_fwd,
    output pipe_ctrl_pkg::redirect_t       redirect,
    output logic [pipe_ctrl_pkg::xlen-1:0] csr_rdata
);
    import pipe_ctrl_pkg::*;

    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic            trap_take;

    // Operand bypass into EX.
    forward_unit u_forward (
        .id      (id),
        .ex      (ex),
        .mem     (mem),
        .rs1_fwd (rs1_fwd),
        .rs2_fwd (rs2_fwd)
    );

    redirect_unit u_redirect (
        .id        (id),
        .ex        (ex),
        .mtvec     (mtvec),
        .mepc      (mepc),
        .redirect  (redirect),
        .trap_take (trap_take)
    );

    // The ecall being taken is the one in ID.
    trap_csr u_trap_csr (
        .clock     (clock),
        .reset     (reset),
        .csr_wr    (csr_wr),
        .trap_take (trap_take),
        .trap_pc   (id.pc),
        .csr_raddr (csr_raddr),
        .mtvec     (mtvec),
        .mepc      (mepc),
        .csr_rdata (csr_rdata)
    );

endmodule

/* hw/trap_csr.sv */
`timescale 1ns/1ns

module trap_csr (
    input  logic                           clock,
    input  logic                           reset,
    input  pipe_ctrl_pkg::csr_wr_t         csr_wr,
    input  logic                           trap_take,
    input  logic [pipe_ctrl_pkg::xlen-1:0] trap_pc,
    input  pipe_ctrl_pkg::csr_addr_e       csr_raddr,
    output logic [pipe_ctrl_pkg::xlen-1:0] mtvec,
    output logic [pipe_ctrl_pkg::xlen-1:0] mepc,
    output logic [pipe_ctrl_pkg::xlen-1:0] csr_rdata
);
    import pipe_ctrl_pkg::*;

    logic [xlen-1:0] mtvec_q;
    logic [xlen-1:0] mepc_q;
    logic [xlen-1:0] mcause_q;

    logic mtvec_we;
    logic mepc_we;
    logic mcause_we;

    // Address decode of the write strobe.
    always_comb begin
        mtvec_we  = 1'b0;
        mepc_we   = 1'b0;
        mcause_we = 1'b0;
        if (csr_wr.valid) begin
            case (csr_wr.addr)
                csr_mtvec:  mtvec_we = 1'b1;
                csr_mepc:   mepc_we = 1'b1;
                csr_mcause: mcause_we = 1'b1;
                default: begin
                    mtvec_we  = 1'b0;
                    mepc_we   = 1'b0;
                    mcause_we = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mtvec_q <= '0;
        end else if (mtvec_we) begin
            mtvec_q <= csr_wr.data;
        end
    end

    // Trap capture has priority over a software write.
    always_ff @(posedge clock) begin
        if (reset) begin
            mepc_q <= '0;
        end else if (trap_take) begin
            mepc_q <= trap_pc;
        end else if (mepc_we) begin
            mepc_q <= csr_wr.data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mcause_q <= '0;
        end else if (trap_take) begin
            mcause_q <= cause_ecall_m;
        end else if (mcause_we) begin
            mcause_q <= csr_wr.data;
        end
    end

    assign mtvec = mtvec_q;
    assign mepc  = mepc_q;

    // Unknown addresses read as zero.
    always_comb begin
        case (csr_raddr)
            csr_mtvec:  csr_rdata = mtvec_q;
            csr_mepc:   csr_rdata = mepc_q;
            csr_mcause: csr_rdata = mcause_q;
            default:    csr_rdata = '0;
        endcase
    end

endmodule

/* hw/redirect_unit.sv */
`timescale 1ns/1ns

module redirect_unit (
    input  pipe_ctrl_pkg::id_stage_t       id,
    input  pipe_ctrl_pkg::ex_stage_t       ex,
    input  logic [pipe_ctrl_pkg::xlen-1:0] mtvec,
    input  logic [pipe_ctrl_pkg::xlen-1:0] mepc,
    output pipe_ctrl_pkg::redirect_t       redirect,
    output logic                           trap_take
);
    import pipe_ctrl_pkg::*;

    redir_kind_e     kind;
    logic            ex_redirect;
    logic            branch_taken;
    logic            redir_valid;
    logic [xlen-1:0] branch_target;
    logic [xlen-1:0] seq_target;
    logic [xlen-1:0] target;

    assign branch_taken = ex.branch && ex.result[0];
    assign ex_redirect  = ex.valid && (ex.jump || ex.fence_i || branch_taken);

    assign branch_target = ex.pc + ex.imm;
    assign seq_target    = ex.pc + inst_bytes;

    // Older instruction in EX beats a trap sitting in ID.
    always_comb begin
        kind = redir_none;
        if (ex_redirect) begin
            if (ex.jump) begin
                kind = redir_jump;
            end else if (branch_taken) begin
                kind = redir_branch;
            end else begin
                kind = redir_fence;
            end
        end else if (id.valid) begin
            if (id.ecall) begin
                kind = redir_ecall;
            end else if (id.mret) begin
                kind = redir_mret;
            end
        end
    end

    always_comb begin
        case (kind)
            redir_jump:   target = ex.result;
            redir_branch: target = branch_target;
            redir_fence:  target = seq_target;
            redir_ecall:  target = mtvec;
            redir_mret:   target = mepc;
            default:      target = '0;
        endcase
    end

    assign redir_valid = (kind != redir_none);

    // Any redirect kills the instruction in ID.
    assign redirect.valid      = redir_valid;
    assign redirect.target     = target;
    assign redirect.flush      = redir_valid;
    assign redirect.icache_clr = ex_redirect && ex.fence_i;

    // Ecall squashed by an EX redirect never reaches the CSRs.
    assign trap_take = (kind == redir_ecall);

endmodule

/* hw/forward_unit.sv */
`timescale 1ns/1ns

module forward_unit (
    input  pipe_ctrl_pkg::id_stage_t       id,
    input  pipe_ctrl_pkg::ex_stage_t       ex,
    input  pipe_ctrl_pkg::mem_stage_t      mem,
    output logic [pipe_ctrl_pkg::xlen-1:0] rs1_fwd,
    output logic [pipe_ctrl_pkg::xlen-1:0] rs2_fwd
);
    import pipe_ctrl_pkg::*;

    logic     ex_writes;
    logic     mem_writes;
    fwd_sel_e rs1_sel;
    fwd_sel_e rs2_sel;

    // Only a live stage that writes back can be a source.
    assign ex_writes  = ex.valid && ex.reg_wen;
    assign mem_writes = mem.valid && mem.reg_wen;

    // EX is the younger producer, so it wins over MEM.
    function automatic fwd_sel_e select_source(
        input logic [reg_addr_w-1:0] src,
        input logic                  ex_hit_en,
        input logic [reg_addr_w-1:0] ex_rd,
        input logic                  mem_hit_en,
        input logic [reg_addr_w-1:0] mem_rd,
        input logic                  mem_is_load
    );
        fwd_sel_e sel;
        sel = fwd_reg;
        if (src != '0) begin
            if (ex_hit_en && (ex_rd == src)) begin
                sel = fwd_ex;
            end else if (mem_hit_en && (mem_rd == src)) begin
                sel = mem_is_load ? fwd_mem_load : fwd_mem_alu;
            end
        end
        return sel;
    endfunction

    function automatic logic [xlen-1:0] pick_operand(
        input fwd_sel_e        sel,
        input logic [xlen-1:0] reg_value,
        input logic [xlen-1:0] ex_result,
        input logic [xlen-1:0] mem_result,
        input logic [xlen-1:0] mem_rdata
    );
        logic [xlen-1:0] value;
        case (sel)
            fwd_ex:       value = ex_result;
            fwd_mem_alu:  value = mem_result;
            fwd_mem_load: value = mem_rdata;
            default:      value = reg_value;
        endcase
        return value;
    endfunction

    always_comb begin
        rs1_sel = select_source(id.rs1, ex_writes, ex.rd, mem_writes, mem.rd, mem.mem_ren);
        rs2_sel = select_source(id.rs2, ex_writes, ex.rd, mem_writes, mem.rd, mem.mem_ren);
    end

    // Loaded data goes straight from MEM, no load-use stall.
    always_comb begin
        rs1_fwd = pick_operand(rs1_sel, id.rs1_value, ex.result, mem.result, mem.rdata);
        rs2_fwd = pick_operand(rs2_sel, id.rs2_value, ex.result, mem.result, mem.rdata);
    end

endmodule

/* hw/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    // Fixed by the RV32 ISA.
    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_addr_w = 12;

    // Sequential fetch step, used for the fence.i restart.
    localparam logic [xlen-1:0] inst_bytes = 32'd4;

    // Environment call from M-mode.
    localparam logic [xlen-1:0] cause_ecall_m = 32'd11;

    typedef enum logic [csr_addr_w-1:0] {
        csr_mtvec  = 12'h305,
        csr_mepc   = 12'h341,
        csr_mcause = 12'h342
    } csr_addr_e;

    typedef enum logic [1:0] {
        fwd_reg      = 2'b00,
        fwd_ex       = 2'b01,
        fwd_mem_alu  = 2'b10,
        fwd_mem_load = 2'b11
    } fwd_sel_e;

    // Which event steers the front end this cycle.
    typedef enum logic [2:0] {
        redir_none,
        redir_jump,
        redir_branch,
        redir_fence,
        redir_ecall,
        redir_mret
    } redir_kind_e;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       rs1_value;
        logic [xlen-1:0]       rs2_value;
        logic                  ecall;
        logic                  mret;
    } id_stage_t;

    // Branch outcome comes back in bit 0 of result.
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       result;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_wen;
        logic                  jump;
        logic                  branch;
        logic                  fence_i;
    } ex_stage_t;

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_wen;
        logic                  mem_ren;
        logic [xlen-1:0]       result;
        logic [xlen-1:0]       rdata;
    } mem_stage_t;

    typedef struct packed {
        logic            valid;
        csr_addr_e       addr;
        logic [xlen-1:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
        logic            flush;
        logic            icache_clr;
    } redirect_t;

endpackage
